// File: common/npc_pkg.sv
// NPC shared definitions
package npc_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE,
    MEM_LD,
    MEM_LW,
    MEM_SD,
    MEM_SW
  } mem_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL
  } br_e;

  // the address is a byte address and the memory only looks at its doubleword index bits.
  typedef struct packed {
    xlen_t      addr;
    logic       we;
    logic [7:0] wmask;
    xlen_t      wdata;
  } mem_req_t;

  typedef struct packed {
    xlen_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_a_pc;
    logic       alu_b_imm;
    br_e        br;
    mem_op_e    mem_op;
    wb_sel_e    wb_sel;
    logic       reg_we;
    logic       is_ebreak;
    logic       is_bad;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } ctrl_t;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [4:0] REG_A0 = 5'd10;

endpackage

// File: mem/npc_mem_arb.sv
// NPC memory arbiter
`timescale 1ns/1ps

module npc_mem_arb (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  npc_pkg::mem_req_t i_req0,
  input  logic              i_req0_valid,
  input  npc_pkg::mem_req_t i_req1,
  input  logic              i_req1_valid,
  output logic              o_gnt0,
  output logic              o_gnt1,
  output npc_pkg::mem_req_t o_mem_req,
  output logic              o_mem_req_valid,
  input  npc_pkg::mem_rsp_t i_mem_rsp,
  output npc_pkg::mem_rsp_t o_rsp0,
  output logic              o_rsp0_valid,
  output npc_pkg::mem_rsp_t o_rsp1,
  output logic              o_rsp1_valid
);

  logic fwd_q;
  logic owner1_q;

  // port 0 always wins a tie.
  assign o_gnt0          = i_req0_valid;
  assign o_gnt1          = i_req1_valid && !i_req0_valid;
  assign o_mem_req       = i_req0_valid ? i_req0 : i_req1;
  assign o_mem_req_valid = o_gnt0 || o_gnt1;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fwd_q    <= 1'b0;
      owner1_q <= 1'b0;
    end else begin
      fwd_q    <= o_mem_req_valid;
      owner1_q <= o_gnt1;
    end
  end

  assign o_rsp0       = i_mem_rsp;
  assign o_rsp1       = i_mem_rsp;
  assign o_rsp0_valid = fwd_q && !owner1_q;
  assign o_rsp1_valid = fwd_q && owner1_q;

  a_arb_onehot_gnt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_gnt0 && o_gnt1));

  a_arb_loser_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_req1_valid && !o_gnt1) |=> i_req1_valid);

endmodule

// File: mem/npc_sram.sv
// NPC unified memory
`timescale 1ns/1ps

module npc_sram #(
  parameter int MEM_WORDS = 1024
) (
  input  logic              i_clk,
  input  npc_pkg::mem_req_t i_req,
  input  logic              i_req_valid,
  output npc_pkg::mem_rsp_t o_rsp,
  input  logic              i_host_en,
  input  logic              i_host_we,
  input  npc_pkg::xlen_t    i_host_addr,
  input  npc_pkg::xlen_t    i_host_wdata,
  output npc_pkg::xlen_t    o_host_rdata
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [63:0]   mem [MEM_WORDS];
  logic [AW-1:0] idx;
  logic [AW-1:0] host_idx;
  logic [63:0]   rdata_q;
  logic [63:0]   host_rdata_q;

  assign idx      = i_req.addr[3 +: AW];
  assign host_idx = i_host_addr[3 +: AW];

  always_ff @(posedge i_clk) begin
    if (i_host_en) begin
      if (i_host_we) mem[host_idx] <= i_host_wdata;
      host_rdata_q <= mem[host_idx];
    end else if (i_req_valid) begin
      for (int b = 0; b < 8; b++) begin
        if (i_req.we && i_req.wmask[b]) mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
      end
      rdata_q <= mem[idx];
    end
  end

  assign o_rsp.rdata  = rdata_q;
  assign o_host_rdata = host_rdata_q;

endmodule

// File: verilog/npc_ifu.sv
// NPC fetch and sequencing unit
`timescale 1ns/1ps

module npc_ifu #(
  parameter npc_pkg::xlen_t RESET_PC    = 64'h0000_0000_8000_0000,
  parameter int             MEM_CREDITS = 2
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_run,
  input  npc_pkg::xlen_t    i_next_pc,
  input  npc_pkg::ctrl_t    i_ctrl,
  input  logic              i_lsu_done,
  output npc_pkg::mem_req_t o_req,
  output logic              o_req_valid,
  input  logic              i_gnt,
  input  npc_pkg::mem_rsp_t i_rsp,
  input  logic              i_rsp_valid,
  output npc_pkg::xlen_t    o_pc,
  output npc_pkg::inst_t    o_inst,
  output logic              o_lsu_start,
  output logic              o_commit,
  output logic              o_halt,
  output logic              o_bad_inst,
  output npc_pkg::xlen_t    o_halt_pc
);
  import npc_pkg::*;

  localparam int            CW       = $clog2(MEM_CREDITS + 1);
  localparam logic [CW-1:0] CRED_MAX = CW'(MEM_CREDITS);

  typedef enum logic [2:0] {S_FETCH, S_WAIT, S_EXEC, S_MEM, S_HALT} state_e;

  state_e        state;
  xlen_t         pc;
  inst_t         inst_q;
  logic [CW-1:0] credits;
  logic          spend;
  logic          halt_now;
  logic          bad_q;

  assign o_req_valid = (state == S_FETCH) && i_run && (credits != '0);
  assign spend       = o_req_valid && i_gnt;
  assign o_req       = '{addr: pc, we: 1'b0, wmask: 8'h00, wdata: '0};

  assign halt_now    = (state == S_EXEC) && (i_ctrl.is_ebreak || i_ctrl.is_bad);
  assign o_lsu_start = (state == S_EXEC) && !halt_now && (i_ctrl.mem_op != MEM_NONE);
  assign o_commit    = ((state == S_EXEC) && !halt_now && (i_ctrl.mem_op == MEM_NONE)) ||
                       ((state == S_MEM) && i_lsu_done);

  // halt shows up in the decode cycle and then holds from the state register.
  assign o_halt     = (state == S_HALT) || halt_now;
  assign o_bad_inst = bad_q || (halt_now && i_ctrl.is_bad);
  assign o_halt_pc  = pc;
  assign o_pc       = pc;
  assign o_inst     = inst_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= S_FETCH;
      pc      <= RESET_PC;
      credits <= CRED_MAX;
      bad_q   <= 1'b0;
    end else begin
      case (state)
        S_FETCH: if (spend) state <= S_WAIT;
        S_WAIT:  if (i_rsp_valid) state <= S_EXEC;
        S_EXEC: begin
          if (halt_now) state <= S_HALT;
          else if (o_lsu_start) state <= S_MEM;
          else state <= S_FETCH;
        end
        S_MEM:   if (i_lsu_done) state <= S_FETCH;
        default: state <= S_HALT;
      endcase
      if (o_commit) pc <= i_next_pc;
      if (halt_now && i_ctrl.is_bad) bad_q <= 1'b1;
      credits <= credits - CW'(spend) + CW'(i_rsp_valid);
    end
  end

  // the fetched doubleword holds two instructions.
  always_ff @(posedge i_clk) begin
    if ((state == S_WAIT) && i_rsp_valid) inst_q <= pc[2] ? i_rsp.rdata[63:32] : i_rsp.rdata[31:0];
  end

  a_ifu_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    credits <= CRED_MAX);

endmodule

// File: verilog/npc_idu.sv
// NPC decoder and register file
`timescale 1ns/1ps

module npc_idu (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  npc_pkg::inst_t i_inst,
  input  logic           i_commit,
  input  npc_pkg::xlen_t i_wb_data,
  output npc_pkg::ctrl_t o_ctrl,
  output npc_pkg::xlen_t o_imm,
  output npc_pkg::xlen_t o_rs1_data,
  output npc_pkg::xlen_t o_rs2_data,
  output npc_pkg::xlen_t o_a0
);
  import npc_pkg::*;

  ctrl_t       ctrl;
  xlen_t       imm;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       imm_b;
  xlen_t       imm_u;
  xlen_t       imm_j;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  xlen_t       regs [32];

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'h000};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    ctrl           = '0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.br        = BR_NONE;
    ctrl.mem_op    = MEM_NONE;
    ctrl.wb_sel    = WB_ALU;
    ctrl.rd        = i_inst[11:7];
    ctrl.rs1       = i_inst[19:15];
    ctrl.rs2       = i_inst[24:20];
    imm            = '0;
    case (i_inst[6:0])
      OPC_OP: begin
        ctrl.reg_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
          {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
          {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
          {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
          {7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
          default:         ctrl.is_bad = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        imm            = imm_i;
        ctrl.is_bad    = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        imm            = imm_u;
      end
      OPC_LOAD: begin
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_sel    = WB_MEM;
        ctrl.reg_we    = 1'b1;
        imm            = imm_i;
        if (funct3 == 3'b011) ctrl.mem_op = MEM_LD;
        else if (funct3 == 3'b010) ctrl.mem_op = MEM_LW;
        else ctrl.is_bad = 1'b1;
      end
      OPC_STORE: begin
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_s;
        if (funct3 == 3'b011) ctrl.mem_op = MEM_SD;
        else if (funct3 == 3'b010) ctrl.mem_op = MEM_SW;
        else ctrl.is_bad = 1'b1;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        if (funct3 == 3'b000) ctrl.br = BR_BEQ;
        else if (funct3 == 3'b001) ctrl.br = BR_BNE;
        else ctrl.is_bad = 1'b1;
      end
      OPC_JAL: begin
        // the ALU forms the jump target, the link comes from pc + 4.
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.br        = BR_JAL;
        ctrl.wb_sel    = WB_PC4;
        ctrl.reg_we    = 1'b1;
        imm            = imm_j;
      end
      OPC_SYSTEM: begin
        if (i_inst == 32'h0010_0073) ctrl.is_ebreak = 1'b1;
        else ctrl.is_bad = 1'b1;
      end
      default: ctrl.is_bad = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_commit && ctrl.reg_we && (ctrl.rd != 5'd0)) begin
      regs[ctrl.rd] <= i_wb_data;
    end
  end

  assign o_ctrl     = ctrl;
  assign o_imm      = imm;
  assign o_rs1_data = regs[ctrl.rs1];
  assign o_rs2_data = regs[ctrl.rs2];
  assign o_a0       = regs[REG_A0];

endmodule

// File: verilog/npc_exu.sv
// NPC execute unit
`timescale 1ns/1ps

module npc_exu (
  input  npc_pkg::ctrl_t i_ctrl,
  input  npc_pkg::xlen_t i_pc,
  input  npc_pkg::xlen_t i_imm,
  input  npc_pkg::xlen_t i_rs1_data,
  input  npc_pkg::xlen_t i_rs2_data,
  input  npc_pkg::xlen_t i_load_data,
  output npc_pkg::xlen_t o_addr,
  output npc_pkg::xlen_t o_next_pc,
  output npc_pkg::xlen_t o_wb_data
);
  import npc_pkg::*;

  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_res;
  xlen_t pc4;
  xlen_t br_tgt;
  logic  rs_eq;

  assign alu_a = i_ctrl.alu_a_pc ? i_pc : i_rs1_data;
  assign alu_b = i_ctrl.alu_b_imm ? i_imm : i_rs2_data;

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    alu_res = alu_a + alu_b;
      ALU_SUB:    alu_res = alu_a - alu_b;
      ALU_AND:    alu_res = alu_a & alu_b;
      ALU_OR:     alu_res = alu_a | alu_b;
      ALU_XOR:    alu_res = alu_a ^ alu_b;
      ALU_SLT:    alu_res = {63'd0, $signed(alu_a) < $signed(alu_b)};
      ALU_PASS_B: alu_res = alu_b;
      default:    alu_res = alu_a + alu_b;
    endcase
  end

  assign o_addr = alu_res;

  assign pc4    = i_pc + 64'd4;
  assign br_tgt = i_pc + i_imm;
  assign rs_eq  = (i_rs1_data == i_rs2_data);

  always_comb begin
    case (i_ctrl.br)
      BR_BEQ:  o_next_pc = rs_eq ? br_tgt : pc4;
      BR_BNE:  o_next_pc = rs_eq ? pc4 : br_tgt;
      BR_JAL:  o_next_pc = alu_res;
      default: o_next_pc = pc4;
    endcase
  end

  always_comb begin
    case (i_ctrl.wb_sel)
      WB_MEM:  o_wb_data = i_load_data;
      WB_PC4:  o_wb_data = pc4;
      default: o_wb_data = alu_res;
    endcase
  end

endmodule

// File: verilog/npc_lsu.sv
// NPC load/store unit
`timescale 1ns/1ps

module npc_lsu #(
  parameter int MEM_CREDITS = 2
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_start,
  input  npc_pkg::mem_op_e  i_mem_op,
  input  npc_pkg::xlen_t    i_addr,
  input  npc_pkg::xlen_t    i_wdata,
  output npc_pkg::mem_req_t o_req,
  output logic              o_req_valid,
  input  logic              i_gnt,
  input  npc_pkg::mem_rsp_t i_rsp,
  input  logic              i_rsp_valid,
  output npc_pkg::xlen_t    o_load_data,
  output logic              o_done
);
  import npc_pkg::*;

  localparam int            CW       = $clog2(MEM_CREDITS + 1);
  localparam logic [CW-1:0] CRED_MAX = CW'(MEM_CREDITS);

  logic [CW-1:0] credits;
  logic          pend_q;
  logic          spend;
  logic          done_q;
  logic [31:0]   word;
  xlen_t         load_q;

  // a request that loses arbitration stays pending until it is granted.
  assign o_req_valid = (i_start || pend_q) && (credits != '0);
  assign spend       = o_req_valid && i_gnt;

  always_comb begin
    o_req.addr  = i_addr;
    o_req.we    = (i_mem_op == MEM_SD) || (i_mem_op == MEM_SW);
    o_req.wdata = i_wdata;
    case (i_mem_op)
      MEM_SD:  o_req.wmask = 8'hff;
      MEM_SW: begin
        o_req.wmask = i_addr[2] ? 8'hf0 : 8'h0f;
        o_req.wdata = {2{i_wdata[31:0]}};
      end
      default: o_req.wmask = 8'h00;
    endcase
  end

  assign word = i_addr[2] ? i_rsp.rdata[63:32] : i_rsp.rdata[31:0];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      credits <= CRED_MAX;
      pend_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      credits <= credits - CW'(spend) + CW'(i_rsp_valid);
      pend_q  <= (i_start || pend_q) && !spend;
      done_q  <= i_rsp_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rsp_valid) load_q <= (i_mem_op == MEM_LW) ? {{32{word[31]}}, word} : i_rsp.rdata;
  end

  assign o_load_data = load_q;
  assign o_done      = done_q;

  a_lsu_rsp_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp_valid |-> credits != CRED_MAX);

endmodule

// File: verilog/npc_soc.sv
// NPC processor subsystem
`timescale 1ns/1ps

module npc_soc #(
  parameter npc_pkg::xlen_t RESET_PC    = 64'h0000_0000_8000_0000,
  parameter int             MEM_WORDS   = 1024,
  parameter int             MEM_CREDITS = 2
) (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_run,
  input  logic           i_host_en,
  input  logic           i_host_we,
  input  npc_pkg::xlen_t i_host_addr,
  input  npc_pkg::xlen_t i_host_wdata,
  output npc_pkg::xlen_t o_host_rdata,
  output logic           o_halt,
  output logic           o_bad_inst,
  output npc_pkg::xlen_t o_halt_pc,
  output npc_pkg::xlen_t o_a0
);
  import npc_pkg::*;

  ctrl_t    ctrl;
  inst_t    inst;
  xlen_t    pc;
  xlen_t    next_pc;
  xlen_t    imm;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    wb_data;
  xlen_t    lsu_addr;
  xlen_t    load_data;
  logic     commit;
  logic     lsu_start;
  logic     lsu_done;
  mem_req_t ifu_req;
  mem_req_t lsu_req;
  mem_req_t mem_req;
  mem_rsp_t ifu_rsp;
  mem_rsp_t lsu_rsp;
  mem_rsp_t mem_rsp;
  logic     ifu_req_valid;
  logic     lsu_req_valid;
  logic     mem_req_valid;
  logic     ifu_gnt;
  logic     lsu_gnt;
  logic     ifu_rsp_valid;
  logic     lsu_rsp_valid;

  npc_ifu #(.RESET_PC(RESET_PC), .MEM_CREDITS(MEM_CREDITS)) u_ifu (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run),
    .i_next_pc(next_pc), .i_ctrl(ctrl), .i_lsu_done(lsu_done),
    .o_req(ifu_req), .o_req_valid(ifu_req_valid), .i_gnt(ifu_gnt),
    .i_rsp(ifu_rsp), .i_rsp_valid(ifu_rsp_valid),
    .o_pc(pc), .o_inst(inst), .o_lsu_start(lsu_start), .o_commit(commit),
    .o_halt(o_halt), .o_bad_inst(o_bad_inst), .o_halt_pc(o_halt_pc)
  );

  npc_idu u_idu (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_inst(inst), .i_commit(commit), .i_wb_data(wb_data),
    .o_ctrl(ctrl), .o_imm(imm),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_a0(o_a0)
  );

  npc_exu u_exu (
    .i_ctrl(ctrl), .i_pc(pc), .i_imm(imm),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_load_data(load_data),
    .o_addr(lsu_addr), .o_next_pc(next_pc), .o_wb_data(wb_data)
  );

  npc_lsu #(.MEM_CREDITS(MEM_CREDITS)) u_lsu (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(lsu_start),
    .i_mem_op(ctrl.mem_op), .i_addr(lsu_addr), .i_wdata(rs2_data),
    .o_req(lsu_req), .o_req_valid(lsu_req_valid), .i_gnt(lsu_gnt),
    .i_rsp(lsu_rsp), .i_rsp_valid(lsu_rsp_valid),
    .o_load_data(load_data), .o_done(lsu_done)
  );

  // load/store sits on the high-priority port.
  npc_mem_arb u_mem_arb (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_req0(lsu_req), .i_req0_valid(lsu_req_valid),
    .i_req1(ifu_req), .i_req1_valid(ifu_req_valid),
    .o_gnt0(lsu_gnt), .o_gnt1(ifu_gnt),
    .o_mem_req(mem_req), .o_mem_req_valid(mem_req_valid), .i_mem_rsp(mem_rsp),
    .o_rsp0(lsu_rsp), .o_rsp0_valid(lsu_rsp_valid),
    .o_rsp1(ifu_rsp), .o_rsp1_valid(ifu_rsp_valid)
  );

  npc_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
    .i_clk(i_clk),
    .i_req(mem_req), .i_req_valid(mem_req_valid), .o_rsp(mem_rsp),
    .i_host_en(i_host_en), .i_host_we(i_host_we), .i_host_addr(i_host_addr),
    .i_host_wdata(i_host_wdata), .o_host_rdata(o_host_rdata)
  );

endmodule

// File: test/tb_npc_soc.sv
// NPC subsystem testbench
`timescale 1ns/1ps

module tb_npc_soc;

  localparam logic [63:0] RESET_PC  = 64'h0;
  localparam int          TIMEOUT   = 2000;
  localparam logic [31:0] NOP       = 32'h0000_0013;
  localparam logic [31:0] EBREAK    = 32'h0010_0073;
  localparam logic [6:0]  OP_REG    = 7'b0110011;
  localparam logic [6:0]  OP_IMM    = 7'b0010011;
  localparam logic [6:0]  OP_LUI    = 7'b0110111;
  localparam logic [6:0]  OP_LOAD   = 7'b0000011;
  localparam logic [6:0]  OP_STORE  = 7'b0100011;
  localparam logic [6:0]  OP_BRANCH = 7'b1100011;
  localparam logic [6:0]  OP_JAL    = 7'b1101111;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_run;
  logic        i_host_en;
  logic        i_host_we;
  logic [63:0] i_host_addr;
  logic [63:0] i_host_wdata;
  logic [63:0] o_host_rdata;
  logic        o_halt;
  logic        o_bad_inst;
  logic [63:0] o_halt_pc;
  logic [63:0] o_a0;

  logic [31:0] prog [$];
  int          errors = 0;
  int          pass_tests = 0;
  int          fail_tests = 0;
  int          seed = 32'hdcf83378;

  npc_soc #(.RESET_PC(RESET_PC), .MEM_WORDS(1024), .MEM_CREDITS(2)) i_npc_soc (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run),
    .i_host_en(i_host_en), .i_host_we(i_host_we), .i_host_addr(i_host_addr),
    .i_host_wdata(i_host_wdata), .o_host_rdata(o_host_rdata),
    .o_halt(o_halt), .o_bad_inst(o_bad_inst), .o_halt_pc(o_halt_pc), .o_a0(o_a0)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // RV64I instruction encoders.
  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd);
    return {imm, rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, 0, rd, OP_IMM);
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic host_write(input logic [63:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_host_en    <= 1'b1;
    i_host_we    <= 1'b1;
    i_host_addr  <= addr;
    i_host_wdata <= data;
    @(posedge i_clk);
    i_host_en    <= 1'b0;
    i_host_we    <= 1'b0;
  endtask

  // read data is registered, so it is taken one cycle later at the falling edge.
  task automatic host_read(input logic [63:0] addr, output logic [63:0] data);
    @(posedge i_clk);
    i_host_en   <= 1'b1;
    i_host_we   <= 1'b0;
    i_host_addr <= addr;
    @(posedge i_clk);
    i_host_en   <= 1'b0;
    @(negedge i_clk);
    data = o_host_rdata;
  endtask

  task automatic check_mem(input logic [63:0] addr, input logic [63:0] exp);
    logic [63:0] got;
    host_read(addr, got);
    check($sformatf("mem[%h]", addr), got, exp);
  endtask

  task automatic start_program();
    logic [31:0] hi;
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    i_run   <= 1'b0;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int i = 0; i < prog.size(); i += 2) begin
      hi = (i + 1 < prog.size()) ? prog[i+1] : NOP;
      host_write(RESET_PC + 64'(4 * i), {hi, prog[i]});
    end
  endtask

  task automatic run_to_halt(input string name);
    int cycles;
    cycles = 0;
    @(posedge i_clk);
    i_run <= 1'b1;
    while (cycles < TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
      if (o_halt) break;
    end
    if (!o_halt) begin
      $display("%s: the core did not halt within %0d cycles", name, TIMEOUT);
      errors++;
    end
    @(posedge i_clk);
    i_run <= 1'b0;
  endtask

  task automatic test_done(input string name, input int errors_before);
    if (errors == errors_before) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_host_port();
    logic [63:0] data [8];
    logic [31:0] hi;
    logic [31:0] lo;
    int          e0;
    e0 = errors;
    prog.delete();
    start_program();
    for (int k = 0; k < 8; k++) begin
      hi = $random(seed);
      lo = $random(seed);
      data[k] = {hi, lo};
      host_write(64'h1000 + 64'(8 * k), data[k]);
    end
    for (int k = 0; k < 8; k++) check_mem(64'h1000 + 64'(8 * k), data[k]);
    test_done("host_port", e0);
  endtask

  task automatic test_alu();
    logic [63:0] exp [12];
    int          e0;
    e0 = errors;
    exp[1]  = -64'sd5;
    exp[2]  = 64'h0000_0000_1234_5678;
    exp[3]  = 64'hffff_ffff_8000_1000;
    exp[4]  = exp[1] + exp[2];
    exp[5]  = exp[1] - exp[2];
    exp[6]  = exp[2] & exp[3];
    exp[7]  = exp[1] | exp[3];
    exp[8]  = exp[2] ^ exp[3];
    exp[9]  = ($signed(exp[1]) < $signed(exp[2])) ? 64'd1 : 64'd0;
    exp[11] = ($signed(exp[2]) < $signed(exp[1])) ? 64'd1 : 64'd0;
    exp[10] = exp[4] + exp[5];
    prog.delete();
    prog.push_back(addi(1, 0, -5));
    prog.push_back(u_type(20'h12345, 2));
    prog.push_back(addi(2, 2, 'h678));
    prog.push_back(u_type(20'h80001, 3));
    prog.push_back(r_type(7'h00, 2, 1, 0, 4));
    prog.push_back(r_type(7'h20, 2, 1, 0, 5));
    prog.push_back(r_type(7'h00, 3, 2, 7, 6));
    prog.push_back(r_type(7'h00, 3, 1, 6, 7));
    prog.push_back(r_type(7'h00, 3, 2, 4, 8));
    prog.push_back(r_type(7'h00, 2, 1, 2, 9));
    prog.push_back(r_type(7'h00, 1, 2, 2, 11));
    prog.push_back(r_type(7'h00, 5, 4, 0, 10));
    for (int r = 1; r < 12; r++) begin
      if (r != 10) prog.push_back(s_type('h400 + 8 * r, r, 0, 3));
    end
    prog.push_back(EBREAK);
    start_program();
    run_to_halt("alu");
    for (int r = 1; r < 12; r++) begin
      if (r != 10) check_mem(64'h400 + 64'(8 * r), exp[r]);
    end
    check("o_a0", o_a0, exp[10]);
    check("o_bad_inst", o_bad_inst, 64'd0);
    test_done("alu", e0);
  endtask

  task automatic test_load_store();
    logic [63:0] x1;
    logic [63:0] old0;
    logic [63:0] old1;
    int          e0;
    e0   = errors;
    x1   = 64'hffff_ffff_89ab_cdef;
    old0 = 64'h1111_2222_3333_4444;
    old1 = 64'haaaa_bbbb_cccc_dddd;
    prog.delete();
    prog.push_back(u_type(20'h89abd, 1));
    prog.push_back(addi(1, 1, -529));
    prog.push_back(s_type('h504, 1, 0, 2));
    prog.push_back(addi(2, 0, 'h123));
    prog.push_back(s_type('h508, 2, 0, 2));
    prog.push_back(i_type('h504, 0, 2, 3, OP_LOAD));
    prog.push_back(s_type('h510, 3, 0, 3));
    prog.push_back(i_type('h500, 0, 2, 4, OP_LOAD));
    prog.push_back(s_type('h518, 4, 0, 3));
    prog.push_back(s_type('h520, 1, 0, 3));
    prog.push_back(i_type('h520, 0, 3, 10, OP_LOAD));
    prog.push_back(EBREAK);
    start_program();
    host_write(64'h500, old0);
    host_write(64'h508, old1);
    run_to_halt("load_store");
    check_mem(64'h500, {x1[31:0], old0[31:0]});
    check_mem(64'h508, {old1[63:32], 32'h0000_0123});
    check_mem(64'h510, {{32{x1[31]}}, x1[31:0]});
    check_mem(64'h518, {{32{old0[31]}}, old0[31:0]});
    check("o_a0", o_a0, x1);
    check("o_bad_inst", o_bad_inst, 64'd0);
    test_done("load_store", e0);
  endtask

  task automatic test_branch();
    int n;
    int e0;
    e0 = errors;
    n  = 10;
    prog.delete();
    prog.push_back(addi(1, 0, n));
    prog.push_back(addi(10, 0, 0));
    prog.push_back(r_type(7'h00, 1, 10, 0, 10));
    prog.push_back(addi(1, 1, -1));
    prog.push_back(b_type(-8, 0, 1, 1));
    prog.push_back(j_type(8, 5));
    // the jump skips this poisoning instruction.
    prog.push_back(addi(10, 0, -1));
    prog.push_back(s_type('h600, 5, 0, 3));
    prog.push_back(EBREAK);
    start_program();
    run_to_halt("branch");
    check_mem(64'h600, RESET_PC + 64'd24);
    check("o_a0", o_a0, 64'(n * (n + 1) / 2));
    check("o_halt_pc", o_halt_pc, RESET_PC + 64'd32);
    check("o_bad_inst", o_bad_inst, 64'd0);
    test_done("branch", e0);
  endtask

  task automatic test_bad_inst();
    int e0;
    e0 = errors;
    prog.delete();
    prog.push_back(addi(10, 0, 5));
    prog.push_back(addi(1, 0, 1));
    prog.push_back(32'hffff_ffff);
    prog.push_back(EBREAK);
    start_program();
    run_to_halt("bad_inst");
    @(negedge i_clk);
    check("o_halt", o_halt, 64'd1);
    check("o_bad_inst", o_bad_inst, 64'd1);
    check("o_halt_pc", o_halt_pc, RESET_PC + 64'd8);
    check("o_a0", o_a0, 64'd5);
    test_done("bad_inst", e0);
  endtask

  task automatic test_random_data();
    logic [63:0] a [4];
    logic [63:0] b [4];
    logic [31:0] hi;
    logic [31:0] lo;
    int          e0;
    e0 = errors;
    prog.delete();
    for (int k = 0; k < 4; k++) begin
      prog.push_back(i_type('h700 + 16 * k, 0, 3, 1, OP_LOAD));
      prog.push_back(i_type('h708 + 16 * k, 0, 3, 2, OP_LOAD));
      prog.push_back(r_type(7'h00, 2, 1, 0, 3));
      prog.push_back(r_type(7'h20, 2, 1, 0, 4));
      prog.push_back(r_type(7'h00, 2, 1, 4, 5));
      prog.push_back(s_type('h740 + 24 * k, 3, 0, 3));
      prog.push_back(s_type('h748 + 24 * k, 4, 0, 3));
      prog.push_back(s_type('h750 + 24 * k, 5, 0, 3));
    end
    prog.push_back(EBREAK);
    start_program();
    for (int k = 0; k < 4; k++) begin
      hi   = $random(seed);
      lo   = $random(seed);
      a[k] = {hi, lo};
      hi   = $random(seed);
      lo   = $random(seed);
      b[k] = {hi, lo};
      host_write(64'h700 + 64'(16 * k), a[k]);
      host_write(64'h708 + 64'(16 * k), b[k]);
    end
    run_to_halt("random_data");
    for (int k = 0; k < 4; k++) begin
      check_mem(64'h740 + 64'(24 * k), a[k] + b[k]);
      check_mem(64'h748 + 64'(24 * k), a[k] - b[k]);
      check_mem(64'h750 + 64'(24 * k), a[k] ^ b[k]);
    end
    check("o_bad_inst", o_bad_inst, 64'd0);
    test_done("random_data", e0);
  endtask

  initial begin
    i_rst_n      = 1'b0;
    i_run        = 1'b0;
    i_host_en    = 1'b0;
    i_host_we    = 1'b0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    test_host_port();
    test_alu();
    test_load_store();
    test_branch();
    test_bad_inst();
    test_random_data();
    $display("tests passed %0d failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/npc_pkg.sv
mem/npc_mem_arb.sv
mem/npc_sram.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_exu.sv
verilog/npc_lsu.sv
verilog/npc_soc.sv
test/tb_npc_soc.sv
